// ==== src/hbm_bist_pkg.sv ====
package hbm_bist_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // AXI4 port widths of one HBM pseudo channel
    ////////////////////////////////////////////////////////////////////////////

    localparam int AXI_ADDR_W = 33;
    localparam int AXI_DATA_W = 256;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;    // One strobe per byte lane

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [3:0]            axi_len_t;     // Beats minus one
    typedef logic [2:0]            axi_size_t;    // Log2 of bytes per beat
    typedef logic [1:0]            axi_burst_t;
    typedef logic [5:0]            axi_id_t;

    // Status counters seen by the host
    typedef logic [31:0] count_t;

    // Which engines run; any other code leaves both idle
    typedef enum logic [2:0]
    {
        MODE_READ  = 3'd0,
        MODE_WRITE = 3'd1,
        MODE_BOTH  = 3'd2
    } bist_mode_t;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed burst shape and traffic constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int         BEATS_PER_BURST = 16;
    localparam axi_len_t   AXI_LEN         = axi_len_t'(BEATS_PER_BURST - 1);
    localparam axi_size_t  BEAT_SIZE       = 3'd5;           // 32 bytes per beat
    localparam axi_burst_t BURST_INCR      = 2'b01;

    localparam logic [31:0] DATA_PATTERN = 32'ha5a5_a5a5;  // Repeated across the beat

    // Each port gets its own 256 MB window
    localparam axi_addr_t PORT_STRIDE  = 33'h1000_0000;
    // Low five address bits are ignored by the controller, keep it 32-byte aligned
    localparam axi_addr_t WRITE_OFFSET = 33'h100;

endpackage

// ==== src/hbm_read_engine.sv ====
module hbm_read_engine #(
    parameter int unsigned bist_num       = 0,     // Port index
    parameter int unsigned bursts_per_run = 15
) (
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,

    input  logic                     start,
    input  hbm_bist_pkg::bist_mode_t mode,

    // Read address channel
    output hbm_bist_pkg::axi_addr_t  axi_araddr,
    output hbm_bist_pkg::axi_len_t   axi_arlen,
    output hbm_bist_pkg::axi_size_t  axi_arsize,
    output hbm_bist_pkg::axi_burst_t axi_arburst,
    output hbm_bist_pkg::axi_id_t    axi_arid,
    output logic                     axi_arvalid,
    input  logic                     axi_arready,

    // Read data channel, payload is dropped
    input  logic                     axi_rvalid,
    input  logic                     axi_rlast,
    output logic                     axi_rready,

    output hbm_bist_pkg::count_t     total_reads,
    output hbm_bist_pkg::count_t     read_ticks
);
    import hbm_bist_pkg::*;

    localparam int unsigned BURST_W = (bursts_per_run > 1) ? $clog2(bursts_per_run) : 1;
    localparam logic [BURST_W-1:0] LAST_BURST = BURST_W'(bursts_per_run - 1);

    localparam axi_addr_t READ_BASE = axi_addr_t'(bist_num) * PORT_STRIDE;

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA} state_t;

    state_t             state;
    state_t             state_nxt;
    logic [BURST_W-1:0] burst_cnt;      // Bursts done in this run

    logic rd_en;
    logic beat_acc;
    logic last_acc;
    logic run_done;

    ////////////////////////////////////////////////////////////////////////////
    // Constant burst description
    ////////////////////////////////////////////////////////////////////////////

    assign axi_araddr  = READ_BASE;
    assign axi_arlen   = AXI_LEN;
    assign axi_arsize  = BEAT_SIZE;
    assign axi_arburst = BURST_INCR;
    assign axi_arid    = '0;

    assign rd_en = start && ((mode == MODE_READ) || (mode == MODE_BOTH));

    assign axi_arvalid = (state == ST_ADDR);
    assign axi_rready  = (state == ST_DATA);   // Held for the whole burst

    assign beat_acc = axi_rvalid && axi_rready;
    assign last_acc = beat_acc && axi_rlast;
    assign run_done = last_acc && (burst_cnt == LAST_BURST);

    ////////////////////////////////////////////////////////////////////////////
    // Burst FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
                if (rd_en)
                    state_nxt = ST_ADDR;
            ST_ADDR:
                if (!rd_en)
                    state_nxt = ST_IDLE;        // Stop right away
                else if (axi_arready)
                    state_nxt = ST_DATA;
            ST_DATA:
                if (!rd_en)
                    state_nxt = ST_IDLE;
                else if (last_acc)
                    state_nxt = ST_ADDR;        // Next burst, same address
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Run, beat and tick counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            burst_cnt   <= '0;
            total_reads <= '0;
            read_ticks  <= '0;
        end
        else if (run_done)
        begin
            // Run complete, start the next one from zero
            burst_cnt   <= '0;
            total_reads <= '0;
            read_ticks  <= '0;
        end
        else
        begin
            if (last_acc)
                burst_cnt <= burst_cnt + 1'b1;
            if (beat_acc)
                total_reads <= total_reads + 1'b1;
            if (axi_arvalid || axi_rready)
                read_ticks <= read_ticks + 1'b1;   // Active cycle
        end
    end

endmodule

// ==== src/hbm_write_engine.sv ====
module hbm_write_engine #(
    parameter int unsigned bist_num       = 0,     // Port index
    parameter int unsigned bursts_per_run = 15
) (
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,

    input  logic                     start,
    input  hbm_bist_pkg::bist_mode_t mode,

    // Write address channel
    output hbm_bist_pkg::axi_addr_t  axi_awaddr,
    output hbm_bist_pkg::axi_len_t   axi_awlen,
    output hbm_bist_pkg::axi_size_t  axi_awsize,
    output hbm_bist_pkg::axi_burst_t axi_awburst,
    output hbm_bist_pkg::axi_id_t    axi_awid,
    output logic                     axi_awvalid,
    input  logic                     axi_awready,

    // Write data channel
    output hbm_bist_pkg::axi_data_t  axi_wdata,
    output hbm_bist_pkg::axi_strb_t  axi_wstrb,
    output logic                     axi_wlast,
    output logic                     axi_wvalid,
    input  logic                     axi_wready,

    // Write response channel
    input  logic                     axi_bvalid,
    output logic                     axi_bready,

    output hbm_bist_pkg::count_t     total_writes,
    output hbm_bist_pkg::count_t     write_ticks
);
    import hbm_bist_pkg::*;

    localparam int unsigned BURST_W = (bursts_per_run > 1) ? $clog2(bursts_per_run) : 1;
    localparam logic [BURST_W-1:0] LAST_BURST = BURST_W'(bursts_per_run - 1);

    localparam axi_addr_t WRITE_BASE = axi_addr_t'(bist_num) * PORT_STRIDE + WRITE_OFFSET;

    typedef enum logic [1:0] {ST_IDLE, ST_FIRST, ST_BEATS, ST_RESP} state_t;

    state_t             state;
    state_t             state_nxt;
    logic               aw_done;        // Address taken, first beat may still wait
    logic               w_done;         // First beat taken, address may still wait
    axi_len_t           beat_cnt;       // Beats accepted in this burst
    logic [BURST_W-1:0] burst_cnt;

    logic wr_en;
    logic aw_acc;
    logic w_acc;
    logic aw_ok;
    logic w_ok;
    logic last_acc;
    logic b_acc;
    logic run_done;

    ////////////////////////////////////////////////////////////////////////////
    // Constant burst description and payload
    ////////////////////////////////////////////////////////////////////////////

    assign axi_awaddr  = WRITE_BASE;
    assign axi_awlen   = AXI_LEN;
    assign axi_awsize  = BEAT_SIZE;
    assign axi_awburst = BURST_INCR;
    assign axi_awid    = '0;

    assign axi_wdata = {(AXI_DATA_W / 32){DATA_PATTERN}};
    assign axi_wstrb = '1;                      // Full beats only

    assign wr_en = start && ((mode == MODE_WRITE) || (mode == MODE_BOTH));

    // Each valid drops on its own after the transfer
    assign axi_awvalid = (state == ST_FIRST) && !aw_done;
    assign axi_wvalid  = ((state == ST_FIRST) && !w_done) || (state == ST_BEATS);
    assign axi_wlast   = axi_wvalid && (beat_cnt == AXI_LEN);
    assign axi_bready  = (state == ST_RESP);

    assign aw_acc   = axi_awvalid && axi_awready;
    assign w_acc    = axi_wvalid && axi_wready;
    assign aw_ok    = aw_done || aw_acc;
    assign w_ok     = w_done || w_acc;
    assign last_acc = w_acc && axi_wlast;
    assign b_acc    = axi_bvalid && axi_bready;
    assign run_done = b_acc && (burst_cnt == LAST_BURST);

    ////////////////////////////////////////////////////////////////////////////
    // Burst FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
                if (wr_en)
                    state_nxt = ST_FIRST;
            ST_FIRST:
                if (aw_ok && w_ok)
                    state_nxt = ST_BEATS;
            ST_BEATS:
                if (last_acc)
                    state_nxt = ST_RESP;
            ST_RESP:
                // Start is only looked at between bursts
                if (b_acc)
                    state_nxt = wr_en ? ST_FIRST : ST_IDLE;
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if ((state == ST_FIRST) && !(aw_ok && w_ok))
            begin
                aw_done <= aw_ok;
                w_done  <= w_ok;
            end
            else
            begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Beat position, run and status counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
            beat_cnt <= '0;
        else if (last_acc)
            beat_cnt <= '0;
        else if (w_acc)
            beat_cnt <= beat_cnt + 1'b1;
    end

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            burst_cnt    <= '0;
            total_writes <= '0;
            write_ticks  <= '0;
        end
        else if (run_done)
        begin
            burst_cnt    <= '0;                  // Fresh run
            total_writes <= '0;
            write_ticks  <= '0;
        end
        else
        begin
            if (b_acc)
                burst_cnt <= burst_cnt + 1'b1;
            if (w_acc)
                total_writes <= total_writes + 1'b1;
            if (axi_awvalid || axi_wvalid || axi_bready)
                write_ticks <= write_ticks + 1'b1;
        end
    end

endmodule

// ==== src/hbm_bist.sv ====
module hbm_bist #(
    parameter int unsigned bist_num       = 0,     // Port index, selects the address window
    parameter int unsigned bursts_per_run = 15
) (
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,

    // Control
    input  logic                     start,        // Level, runs while high
    input  hbm_bist_pkg::bist_mode_t mode,

    // Status
    output hbm_bist_pkg::count_t     total_reads,
    output hbm_bist_pkg::count_t     total_writes,
    output hbm_bist_pkg::count_t     read_ticks,
    output hbm_bist_pkg::count_t     write_ticks,

    ////////////////////////////////////////////////////////////////////////////
    // AXI4 master port
    ////////////////////////////////////////////////////////////////////////////

    output hbm_bist_pkg::axi_addr_t  axi_awaddr,
    output hbm_bist_pkg::axi_len_t   axi_awlen,
    output hbm_bist_pkg::axi_size_t  axi_awsize,
    output hbm_bist_pkg::axi_burst_t axi_awburst,
    output hbm_bist_pkg::axi_id_t    axi_awid,
    output logic                     axi_awvalid,
    input  logic                     axi_awready,

    output hbm_bist_pkg::axi_data_t  axi_wdata,
    output hbm_bist_pkg::axi_strb_t  axi_wstrb,
    output logic                     axi_wlast,
    output logic                     axi_wvalid,
    input  logic                     axi_wready,

    input  logic                     axi_bvalid,
    output logic                     axi_bready,

    output hbm_bist_pkg::axi_addr_t  axi_araddr,
    output hbm_bist_pkg::axi_len_t   axi_arlen,
    output hbm_bist_pkg::axi_size_t  axi_arsize,
    output hbm_bist_pkg::axi_burst_t axi_arburst,
    output hbm_bist_pkg::axi_id_t    axi_arid,
    output logic                     axi_arvalid,
    input  logic                     axi_arready,

    input  hbm_bist_pkg::axi_data_t  axi_rdata,    // Sink, read data is not checked
    input  logic                     axi_rlast,
    input  logic                     axi_rvalid,
    output logic                     axi_rready
);

    // Read channels
    hbm_read_engine #(
        .bist_num       (bist_num),
        .bursts_per_run (bursts_per_run)
    ) i_read_engine (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .start       (start),
        .mode        (mode),
        .axi_araddr  (axi_araddr),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_arid    (axi_arid),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_rvalid  (axi_rvalid),
        .axi_rlast   (axi_rlast),
        .axi_rready  (axi_rready),
        .total_reads (total_reads),
        .read_ticks  (read_ticks)
    );

    // Write channels
    hbm_write_engine #(
        .bist_num       (bist_num),
        .bursts_per_run (bursts_per_run)
    ) i_write_engine (
        .axi_aclk     (axi_aclk),
        .axi_aresetn  (axi_aresetn),
        .start        (start),
        .mode         (mode),
        .axi_awaddr   (axi_awaddr),
        .axi_awlen    (axi_awlen),
        .axi_awsize   (axi_awsize),
        .axi_awburst  (axi_awburst),
        .axi_awid     (axi_awid),
        .axi_awvalid  (axi_awvalid),
        .axi_awready  (axi_awready),
        .axi_wdata    (axi_wdata),
        .axi_wstrb    (axi_wstrb),
        .axi_wlast    (axi_wlast),
        .axi_wvalid   (axi_wvalid),
        .axi_wready   (axi_wready),
        .axi_bvalid   (axi_bvalid),
        .axi_bready   (axi_bready),
        .total_writes (total_writes),
        .write_ticks  (write_ticks)
    );

endmodule

// ==== dv/hbm_bist_tb.sv ====
module hbm_bist_tb;
    import hbm_bist_pkg::*;

    localparam int        NUM_ROWS  = 9;
    localparam int        RUN_LEN   = 4;                 // Bursts per run in the DUT
    localparam axi_addr_t EXP_RADDR = 2 * PORT_STRIDE;   // Port index 2
    localparam axi_data_t EXP_WDATA = {8{32'ha5a5_a5a5}};

    logic       axi_aclk = 1'b0;
    logic       axi_aresetn;
    logic       start;
    bist_mode_t mode;

    count_t total_reads;
    count_t total_writes;
    count_t read_ticks;
    count_t write_ticks;

    axi_addr_t  axi_awaddr;
    axi_addr_t  axi_araddr;
    axi_len_t   axi_awlen;
    axi_len_t   axi_arlen;
    axi_size_t  axi_awsize;
    axi_size_t  axi_arsize;
    axi_burst_t axi_awburst;
    axi_burst_t axi_arburst;
    axi_id_t    axi_awid;
    axi_id_t    axi_arid;
    logic       axi_awvalid;
    logic       axi_arvalid;
    axi_data_t  axi_wdata;
    axi_strb_t  axi_wstrb;
    logic       axi_wlast;
    logic       axi_wvalid;
    logic       axi_bready;
    logic       axi_rready;

    logic       axi_awready = 1'b0;
    logic       axi_wready  = 1'b0;
    logic       axi_bvalid  = 1'b0;
    logic       axi_arready = 1'b0;
    axi_data_t  axi_rdata   = '0;
    logic       axi_rlast   = 1'b0;
    logic       axi_rvalid  = 1'b0;

    // Stimulus table, one entry per test
    string      row_name   [NUM_ROWS];
    bist_mode_t row_mode   [NUM_ROWS];
    int         row_bursts [NUM_ROWS];
    int         row_stall  [NUM_ROWS];   // Percent of cycles a ready stays low
    int         row_mid    [NUM_ROWS];   // Extra beats before start drops
    int         row_reads  [NUM_ROWS];
    int         row_writes [NUM_ROWS];

    string  cur_name;
    integer seed   = 32'h4217;
    int     stall  = 0;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     limit  = 100000;
    int     rd_pend;
    int     rd_beat;

    // Observed at the ports
    int     rd_beats;
    int     wr_beats;
    int     wr_resps;
    int     rd_run;
    int     wr_run;
    count_t rd_model;
    count_t wr_model;
    count_t rt_model;
    count_t wt_model;
    logic   rzero_due;
    logic   wzero_due;
    logic   aw_seen;
    logic   ar_seen;

    hbm_bist #(
        .bist_num       (2),
        .bursts_per_run (RUN_LEN)
    ) i_dut (.*);

    always #10 axi_aclk = ~axi_aclk;

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_count(input string what, input count_t exp, input count_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("error %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input axi_addr_t exp, input axi_addr_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("error %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("error %s %s: expected %0b, actual %0b", cur_name, what, exp, act);
        end
    endtask

    function automatic logic ready_roll();
        return ($unsigned($random(seed)) % 100) >= stall;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // AXI slave model
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            rd_pend = 0;
            rd_beat = 0;
            axi_arready <= 1'b0;
            axi_rvalid  <= 1'b0;
            axi_rlast   <= 1'b0;
            axi_awready <= 1'b0;
            axi_wready  <= 1'b0;
            axi_bvalid  <= 1'b0;
        end
        else
        begin
            if (axi_arvalid && axi_arready)
                rd_pend++;
            if (axi_rvalid && axi_rready)
            begin
                if (rd_beat == 15)
                begin
                    rd_beat = 0;
                    rd_pend--;
                end
                else
                    rd_beat++;
            end
            if (!axi_rvalid || axi_rready)      // Hold a beat until taken
            begin
                axi_rvalid <= (rd_pend != 0) && ready_roll();
                axi_rlast  <= (rd_beat == 15);
            end
            axi_arready <= ready_roll();
            axi_awready <= ready_roll();
            axi_wready  <= ready_roll();
            if (axi_wvalid && axi_wready && axi_wlast)
                axi_bvalid <= 1'b1;
            else if (axi_bvalid && axi_bready)
                axi_bvalid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Port monitors and expected counters
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            rd_beats  = 0;
            wr_beats  = 0;
            wr_resps  = 0;
            rd_run    = 0;
            wr_run    = 0;
            rd_model  = '0;
            wr_model  = '0;
            rt_model  = '0;
            wt_model  = '0;
            rzero_due = 1'b0;
            wzero_due = 1'b0;
            aw_seen   = 1'b0;
            ar_seen   = 1'b0;
        end
        else
        begin
            if (rzero_due)
            begin
                check_count("total_reads after run", 0, total_reads);
                check_count("read_ticks after run", 0, read_ticks);
                rzero_due = 1'b0;
            end
            if (wzero_due)
            begin
                check_count("total_writes after run", 0, total_writes);
                check_count("write_ticks after run", 0, write_ticks);
                wzero_due = 1'b0;
            end
            aw_seen = aw_seen || axi_awvalid;
            ar_seen = ar_seen || axi_arvalid;

            // Read side, last beat of a run clears instead of counting
            if (axi_rvalid && axi_rready)
                rd_beats++;
            if (axi_rvalid && axi_rready && axi_rlast && rd_run == RUN_LEN - 1)
            begin
                rd_model  = '0;
                rt_model  = '0;
                rd_run    = 0;
                rzero_due = 1'b1;
            end
            else
            begin
                if (axi_rvalid && axi_rready)
                    rd_model++;
                if (axi_rvalid && axi_rready && axi_rlast)
                    rd_run++;
                if (axi_arvalid || axi_rready)
                    rt_model++;
            end

            // Write side
            if (axi_wvalid && axi_wready)
            begin
                check_flag("wlast position", (wr_beats % 16) == 15, axi_wlast);
                wr_beats++;
            end
            if (axi_bvalid && axi_bready)
                wr_resps++;
            if (axi_bvalid && axi_bready && wr_run == RUN_LEN - 1)
            begin
                wr_model  = '0;
                wt_model  = '0;
                wr_run    = 0;
                wzero_due = 1'b1;
            end
            else
            begin
                if (axi_wvalid && axi_wready)
                    wr_model++;
                if (axi_bvalid && axi_bready)
                    wr_run++;
                if (axi_awvalid || axi_wvalid || axi_bready)
                    wt_model++;
            end
        end
    end

    always @(posedge axi_aclk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout: the tests did not finish within %0d cycles", limit);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    task automatic set_row(input int i, input string n, input bist_mode_t m, input int b,
                           input int s, input int mid, input int er, input int ew);
        row_name[i]   = n;
        row_mode[i]   = m;
        row_bursts[i] = b;
        row_stall[i]  = s;
        row_mid[i]    = mid;
        row_reads[i]  = er;
        row_writes[i] = ew;
    endtask

    task automatic run_row(input int r);
        logic rd_on;
        logic wr_on;
        logic rd_exact;
        logic wr_exact;
        int   target;
        int   err_before;

        cur_name   = row_name[r];
        err_before = errors;
        rd_on      = (row_mode[r] == MODE_READ) || (row_mode[r] == MODE_BOTH);
        wr_on      = (row_mode[r] == MODE_WRITE) || (row_mode[r] == MODE_BOTH);
        rd_exact   = (row_mid[r] == 0) && (row_mode[r] != MODE_BOTH);
        wr_exact   = (row_mode[r] != MODE_BOTH);   // Writes stop on a burst boundary
        target     = row_bursts[r] * 16 + row_mid[r];
        stall      = row_stall[r];

        @(posedge axi_aclk);
        axi_aresetn <= 1'b0;
        start       <= 1'b0;
        repeat (3) @(posedge axi_aclk);
        axi_aresetn <= 1'b1;
        mode        <= row_mode[r];
        start       <= 1'b1;

        if (!rd_on && !wr_on)
            repeat (40) @(posedge axi_aclk);
        else
            while ((rd_on && rd_beats < target) || (wr_on && wr_beats < target))
                @(posedge axi_aclk);
        start <= 1'b0;

        // Read side stops one cycle after start falls
        @(posedge axi_aclk);
        @(negedge axi_aclk);
        check_flag("arvalid after stop", 1'b0, axi_arvalid);
        check_flag("rready after stop", 1'b0, axi_rready);
        while (axi_awvalid || axi_wvalid || axi_bready)
            @(negedge axi_aclk);
        repeat (8)
        begin
            @(negedge axi_aclk);
            check_flag("write valids idle", 1'b0, axi_awvalid || axi_wvalid || axi_bready);
        end

        check_count("write bursts closed", count_t'(wr_resps * 16), count_t'(wr_beats));
        check_count("total_reads", rd_model, total_reads);
        check_count("total_writes", wr_model, total_writes);
        check_count("read_ticks", rt_model, read_ticks);
        check_count("write_ticks", wt_model, write_ticks);
        if (rd_exact)
            check_count("reads per table", count_t'(row_reads[r]), rd_model);
        else if (rd_model < count_t'(row_reads[r]))
        begin
            errors++;
            $display("%s: fewer reads were counted than the table needs", cur_name);
        end
        if (wr_exact)
            check_count("writes per table", count_t'(row_writes[r]), wr_model);
        else if (wr_model < count_t'(row_writes[r]))
        begin
            errors++;
            $display("%s: fewer writes were counted than the table needs", cur_name);
        end
        check_flag("ar traffic seen", rd_on, ar_seen);
        check_flag("aw traffic seen", wr_on, aw_seen);
        check_addr("araddr", EXP_RADDR, axi_araddr);
        check_addr("awaddr", EXP_RADDR + WRITE_OFFSET, axi_awaddr);
        check_count("arlen", 15, count_t'(axi_arlen));
        check_count("awlen", 15, count_t'(axi_awlen));
        check_count("arsize", 5, count_t'(axi_arsize));    // 32 bytes per beat
        check_count("awsize", 5, count_t'(axi_awsize));
        check_count("arburst", 1, count_t'(axi_arburst));  // INCR
        check_count("awburst", 1, count_t'(axi_awburst));
        check_count("arid", 0, count_t'(axi_arid));
        check_count("awid", 0, count_t'(axi_awid));
        check_flag("wstrb all ones", 1'b1, axi_wstrb == '1);
        check_flag("wdata pattern", 1'b1, axi_wdata == EXP_WDATA);
        $display("%-12s %s", cur_name, (errors == err_before) ? "ok" : "FAIL");
    endtask

    initial
    begin
        axi_aresetn = 1'b0;
        start       = 1'b0;
        mode        = MODE_READ;

        //           name           mode               bursts stall mid reads writes
        set_row(0, "read_only",   MODE_READ,         3,  0,  0, 48,  0);
        set_row(1, "write_only",  MODE_WRITE,        3, 30,  0,  0, 48);
        set_row(2, "both",        MODE_BOTH,         2,  0,  0, 32, 32);
        set_row(3, "mode_none",   bist_mode_t'(3'd3), 0, 0,  0,  0,  0);
        set_row(4, "ticks_stall", MODE_BOTH,         2, 30,  0, 32, 32);
        set_row(5, "read_drop",   MODE_READ,         1, 20,  5, 21,  0);
        set_row(6, "write_drop",  MODE_WRITE,        1, 20,  5,  0, 32);
        set_row(7, "read_wrap",   MODE_READ,         5, 25,  0, 16,  0);
        set_row(8, "write_wrap",  MODE_WRITE,        5,  0,  0,  0, 16);

        limit = 0;
        for (int i = 0; i < NUM_ROWS; i++)
            limit += (row_bursts[i] + 1) * 16 * 4 + 100;

        for (int i = 0; i < NUM_ROWS; i++)
            run_row(i);

        $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== hbm_bist.f ====
src/hbm_bist_pkg.sv
src/hbm_read_engine.sv
src/hbm_write_engine.sv
src/hbm_bist.sv
dv/hbm_bist_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = hbm_bist_tb
FILELIST  = hbm_bist.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
